// File: rtl/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// router geometry
`define NUM_PORTS 5

// flit slots per input port
`define FIFO_DEPTH 8

// payload bits carried by every flit
`define PAYLOAD_W 16

// header length field, flits incl. header
`define LEN_W 12

`endif

// File: rtl/noc_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

  typedef logic [`PAYLOAD_W-1:0] payloadT;
  typedef logic [`LEN_W-1:0]     pktLenT;

  // one-hot flit kind
  typedef logic [2:0] flitKindT;
  localparam flitKindT HEADER = 3'b001;
  localparam flitKindT BODY   = 3'b010;
  localparam flitKindT TAIL   = 3'b100;

  typedef logic [2:0] portIdxT;
  localparam portIdxT PORT_L = 3'd0;
  localparam portIdxT PORT_N = 3'd1;
  localparam portIdxT PORT_E = 3'd2;
  localparam portIdxT PORT_W = 3'd3;
  localparam portIdxT PORT_S = 3'd4;

  // header flits carry the packet length in data[LEN_W-1:0]
  typedef struct packed {
    flitKindT kind;
    payloadT  data;
  } flitT;

  typedef enum logic [2:0] {
    ARB_IDLE,
    OWN_L,
    OWN_N,
    OWN_E,
    OWN_W,
    OWN_S
  } arbStateT;

endpackage

`default_nettype wire

// File: rtl/linkReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module linkReceiver (
  input  logic           clk,
  input  logic           rst,
  input  logic           req,
  input  noc_pkg::flitT  flit,
  output logic           ack,
  input  logic           full,
  output logic           push,
  output noc_pkg::flitT  writeFlit
);

  import noc_pkg::*;

  typedef enum logic {
    RX_IDLE,
    RX_ACK
  } rxStateT;

  rxStateT rxState;
  flitT    flitReg;
  logic    pushReg;
  logic    accept;

  // new request and room in the fifo
  assign accept = (rxState == RX_IDLE) && req && !full;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rxState <= RX_IDLE;
      pushReg <= 1'b0;
    end
    else
    begin
      pushReg <= accept; // one pulse per handshake
      case (rxState)
        RX_IDLE: if (accept) rxState <= RX_ACK;
        RX_ACK:  if (!req) rxState <= RX_IDLE; // sender dropped req
        default: rxState <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      flitReg <= flit;
  end

  assign ack       = (rxState == RX_ACK);
  assign push      = pushReg;
  assign writeFlit = flitReg;

endmodule

`default_nettype wire

// File: rtl/flitFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module flitFifo (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  noc_pkg::flitT  writeFlit,
  input  logic           pop,
  output noc_pkg::flitT  headFlit,
  output logic           full,
  output logic           notEmpty
);

  import noc_pkg::*;

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`FIFO_DEPTH - 1);
  localparam logic [PTR_W:0]   DEPTH_CNT = (PTR_W + 1)'(`FIFO_DEPTH);

  flitT             mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W:0]   count;
  logic             doPush;
  logic             doPop;

  assign doPush = push && !full; // dropped when full
  assign doPop  = pop && notEmpty;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == LAST_SLOT) ? '0 : wrPtr + 1'b1;
      if (doPop)
        rdPtr <= (rdPtr == LAST_SLOT) ? '0 : rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= writeFlit;
  end

  assign headFlit = mem[rdPtr];
  assign full     = (count == DEPTH_CNT);
  assign notEmpty = (count != '0);

endmodule

`default_nettype wire

// File: rtl/packetArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module packetArbiter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               notEmpty,
  input  noc_pkg::flitKindT [`NUM_PORTS-1:0]  headKind,
  input  noc_pkg::pktLenT [`NUM_PORTS-1:0]    headLen,
  input  logic                                sent,
  output logic [`NUM_PORTS-1:0]               grant
);

  import noc_pkg::*;

  arbStateT             state;
  arbStateT             nextState;
  arbStateT             scanState;
  portIdxT              owner;
  portIdxT              scanIdx;
  logic                 found;
  logic                 leaveGrant;
  logic [`NUM_PORTS-1:0] pktDone;
  pktLenT               cnt    [`NUM_PORTS];
  pktLenT               lenReg [`NUM_PORTS];

  function automatic portIdxT portOf(arbStateT s);
    case (s)
      OWN_L:   return PORT_L;
      OWN_N:   return PORT_N;
      OWN_E:   return PORT_E;
      OWN_W:   return PORT_W;
      default: return PORT_S; // idle scans from local
    endcase
  endfunction

  function automatic arbStateT stateOf(portIdxT p);
    case (p)
      PORT_L:  return OWN_L;
      PORT_N:  return OWN_N;
      PORT_E:  return OWN_E;
      PORT_W:  return OWN_W;
      default: return OWN_S;
    endcase
  endfunction

  assign owner = portOf(state);

  // sent-flit count reached the header length
  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
      pktDone[p] = (cnt[p] != '0) && (cnt[p] == lenReg[p]);
  end

  // rotating search, starting one past the owner, owner itself last
  always_comb
  begin
    scanState = ARB_IDLE;
    scanIdx   = owner;
    found     = 1'b0;
    for (int i = 1; i <= `NUM_PORTS; i++)
    begin
      scanIdx = portIdxT'((int'(owner) + i) % `NUM_PORTS);
      if (!found && notEmpty[scanIdx])
      begin
        scanState = stateOf(scanIdx);
        found     = 1'b1;
      end
    end
  end

  // an empty owner fifo mid-packet just stalls, so packets never interleave
  assign leaveGrant = (state != ARB_IDLE) &&
                      (pktDone[owner] || (!notEmpty[owner] && cnt[owner] == '0));

  always_comb
  begin
    if (state == ARB_IDLE || leaveGrant)
      nextState = scanState;
    else
      nextState = state;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        cnt[p]    <= '0;
        lenReg[p] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        // owner keeps its length once the header has gone
        if (notEmpty[p] && headKind[p] == HEADER && (!grant[p] || cnt[p] == '0))
          lenReg[p] <= headLen[p];
      end
      if (leaveGrant)
        cnt[owner] <= '0;
      else if (sent && state != ARB_IDLE)
        cnt[owner] <= cnt[owner] + 1'b1;
    end
  end

  always_comb
  begin
    grant = '0;
    if (state != ARB_IDLE)
      grant[owner] = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/outputLink.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module outputLink (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [`NUM_PORTS-1:0]            grant,
  input  logic [`NUM_PORTS-1:0]            notEmpty,
  input  noc_pkg::flitT [`NUM_PORTS-1:0]   headFlit,
  output logic [`NUM_PORTS-1:0]            pop,
  output logic                             sent,
  output logic                             outReq,
  output noc_pkg::flitT                    outFlit,
  input  logic                             outAck
);

  import noc_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_WAIT
  } txStateT;

  txStateT txState;
  flitT    selFlit;
  logic    ready;
  logic    load;

  assign ready = |(grant & notEmpty);
  assign load  = (txState == TX_IDLE) && ready;

  // granted fifo head
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      if (grant[p])
        selFlit = headFlit[p];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      txState <= TX_IDLE;
    else
    begin
      case (txState)
        TX_IDLE: if (load) txState <= TX_REQ;
        TX_REQ:  if (outAck) txState <= TX_WAIT; // drop req
        TX_WAIT: if (!outAck) txState <= TX_IDLE; // link free again
        default: txState <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
      outFlit <= selFlit;
  end

  assign pop    = load ? grant : '0;
  assign sent   = load;
  assign outReq = (txState == TX_REQ);

endmodule

`default_nettype wire

// File: rtl/routerOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module routerOutputStage (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [`NUM_PORTS-1:0]            inReq,
  input  noc_pkg::flitT [`NUM_PORTS-1:0]   inFlit,
  output logic [`NUM_PORTS-1:0]            inAck,
  output logic                             outReq,
  output noc_pkg::flitT                    outFlit,
  input  logic                             outAck
);

  import noc_pkg::*;

  logic [`NUM_PORTS-1:0]      push;
  flitT [`NUM_PORTS-1:0]      writeFlit;
  logic [`NUM_PORTS-1:0]      full;
  logic [`NUM_PORTS-1:0]      notEmpty;
  flitT [`NUM_PORTS-1:0]      headFlit;
  flitKindT [`NUM_PORTS-1:0]  headKind;
  pktLenT [`NUM_PORTS-1:0]    headLen;
  logic [`NUM_PORTS-1:0]      pop;
  logic [`NUM_PORTS-1:0]      grant;
  logic                       sent;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gPort
    linkReceiver uRx (
      .clk       (clk),
      .rst       (rst),
      .req       (inReq[p]),
      .flit      (inFlit[p]),
      .ack       (inAck[p]),
      .full      (full[p]),
      .push      (push[p]),
      .writeFlit (writeFlit[p])
    );

    flitFifo uFifo (
      .clk       (clk),
      .rst       (rst),
      .push      (push[p]),
      .writeFlit (writeFlit[p]),
      .pop       (pop[p]),
      .headFlit  (headFlit[p]),
      .full      (full[p]),
      .notEmpty  (notEmpty[p])
    );

    assign headKind[p] = headFlit[p].kind;
    assign headLen[p]  = headFlit[p].data[`LEN_W-1:0]; // length field of a header
  end

  packetArbiter uArb (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .headKind (headKind),
    .headLen  (headLen),
    .sent     (sent),
    .grant    (grant)
  );

  outputLink uOut (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .pop      (pop),
    .sent     (sent),
    .outReq   (outReq),
    .outFlit  (outFlit),
    .outAck   (outAck)
  );

endmodule

`default_nettype wire

// File: tests/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released away from the sampling edge
  end

endmodule

`default_nettype wire

// File: tests/routerOutputStage_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module routerOutputStage_sva (
  input logic                  clk,
  input logic                  rst,
  input logic [`NUM_PORTS-1:0] inReq,
  input logic [`NUM_PORTS-1:0] inAck,
  input logic [`NUM_PORTS-1:0] grant,
  input logic                  outReq,
  input noc_pkg::flitT         outFlit,
  input logic                  outAck
);

  int assertFails = 0; // read back by the testbench

  ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
    (inAck & ~$past(inAck) & ~$past(inReq)) == '0)
    else begin assertFails++; $error("inAck rose without a sampled inReq"); end

  flitHeld: assert property (@(posedge clk) disable iff (rst)
    (outReq && $past(outReq)) |-> (outFlit == $past(outFlit)))
    else begin assertFails++; $error("outFlit changed while outReq was high"); end

  reqAfterAck: assert property (@(posedge clk) disable iff (rst)
    $fell(outReq) |-> $past(outAck))
    else begin assertFails++; $error("outReq fell before outAck was seen"); end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else begin assertFails++; $error("grant is neither zero nor one-hot"); end

endmodule

bind routerOutputStage routerOutputStage_sva uSva (
  .clk     (clk),
  .rst     (rst),
  .inReq   (inReq),
  .inAck   (inAck),
  .grant   (grant),
  .outReq  (outReq),
  .outFlit (outFlit),
  .outAck  (outAck)
);

`default_nettype wire

// File: tests/routerOutputStage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module routerOutputStage_tb;

  import noc_pkg::*;

  localparam int NUM_ROWS      = 40;
  localparam int SHORT_WAIT    = 12;
  localparam int LINK_TIMEOUT  = 400;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int IDLE_TIMEOUT  = 100000;

  // expSlot is the header's place in the output order of its held group
  typedef struct packed {
    portIdxT    port;
    pktLenT     len;
    logic       preload;
    logic       expBlock;
    logic [2:0] expSlot;
  } rowT;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] inReq;
  flitT [`NUM_PORTS-1:0] inFlit;
  logic [`NUM_PORTS-1:0] inAck;
  logic                  outReq;
  flitT                  outFlit;
  logic                  outAck;
  logic                  holdAck; // output withheld while a group loads
  logic                  timedOut = 1'b0; // set by the first timeout

  rowT     stimTable [NUM_ROWS];
  flitT    expQ [`NUM_PORTS][$];
  portIdxT hdrOrder [$];
  portIdxT curPort;
  int      remaining;
  int      valueErrors;
  int      flowErrors;

  tbClock #(.PERIOD_NS(40), .RESET_CYCLES(8)) uClk (.clk(clk), .rst(rst));

  routerOutputStage DUT (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inFlit  (inFlit),
    .inAck   (inAck),
    .outReq  (outReq),
    .outFlit (outFlit),
    .outAck  (outAck)
  );

  task automatic printCounts();
    $display("errors: value %0d, flow %0d, assertion %0d",
             valueErrors, flowErrors, DUT.uSva.assertFails);
  endtask

  task automatic flagTimeout(input string why);
    if (!timedOut)
      $display("timeout at %0t: %s", $time, why);
    timedOut = 1'b1;
  endtask

  task automatic checkFlit(input flitT got);
    flitT expF;
    if (remaining == 0)
    begin
      if (got.kind != HEADER || int'(got.data[`PAYLOAD_W-1 -: 4]) >= `NUM_PORTS)
      begin
        flowErrors++;
        $display("%0t: output sent %h where a packet header was due", $time, got);
        return;
      end
      curPort = portIdxT'(got.data[`PAYLOAD_W-1 -: 4]);
      hdrOrder.push_back(curPort);
    end
    if (expQ[curPort].size() == 0)
    begin
      flowErrors++;
      $display("%0t: output sent %h but port %0d has nothing pending", $time, got, curPort);
      return;
    end
    expF = expQ[curPort].pop_front();
    if (got !== expF)
    begin
      valueErrors++;
      $display("[FAIL] %0t outFlit: expected %h, got %h", $time, expF, got);
    end
    if (remaining == 0)
      remaining = int'(expF.data[`LEN_W-1:0]) - 1; // rest must come from this port
    else
      remaining--;
  endtask

  task automatic sendFlit(input portIdxT p, input flitT f, input logic expectBlock);
    int   n;
    int   limit;
    logic acked;
    @(negedge clk);
    inFlit[p] = f;
    inReq[p]  = 1'b1;
    acked     = 1'b0;
    limit     = holdAck ? SHORT_WAIT : LINK_TIMEOUT;
    n         = 0;
    while (!acked && n < limit && !timedOut)
    begin
      @(negedge clk);
      acked = inAck[p];
      n++;
    end
    if (holdAck && !timedOut && acked == expectBlock)
    begin
      flowErrors++;
      if (acked)
        $display("%0t: port %0d took a flit although its FIFO should be full", $time, p);
      else
        $display("%0t: port %0d held inAck low with FIFO space left", $time, p);
    end
    if (!acked)
      holdAck = 1'b0; // free the output so the FIFO drains
    n = 0;
    while (!acked && n < LINK_TIMEOUT && !timedOut)
    begin
      @(negedge clk);
      acked = inAck[p];
      n++;
    end
    if (!acked)
      flagTimeout($sformatf("inAck of port %0d never rose", p));
    inReq[p] = 1'b0;
    n = 0;
    while (inAck[p] && n < LINK_TIMEOUT && !timedOut)
    begin
      @(negedge clk);
      n++;
    end
    if (inAck[p])
      flagTimeout($sformatf("inAck of port %0d never fell", p));
  endtask

  task automatic sendPacket(input rowT row);
    flitT f;
    int   len;
    len = int'(row.len);
    for (int i = 0; i < len && !timedOut; i++)
    begin
      if (i == 0)
      begin
        f.kind = HEADER;
        f.data = {4'(row.port), row.len};
      end
      else
      begin
        f.kind = (i == len - 1) ? TAIL : BODY;
        f.data = {row.port, 13'($urandom)};
      end
      expQ[row.port].push_back(f);
      sendFlit(row.port, f, row.expBlock && (i == len - 1));
    end
  endtask

  task automatic drainOutput(input string what);
    int   n;
    logic busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < DRAIN_TIMEOUT && !timedOut)
    begin
      @(negedge clk);
      n++;
      busy = outReq || (remaining != 0);
      for (int p = 0; p < `NUM_PORTS; p++)
        if (expQ[p].size() != 0)
          busy = 1'b1;
    end
    if (busy)
      flagTimeout({"output did not drain after ", what});
  endtask

  task automatic checkGroupOrder(input int first, input int last, input int hdrStart);
    int idx;
    for (int k = first; k <= last; k++)
    begin
      idx = hdrStart + int'(stimTable[k].expSlot);
      if (idx >= hdrOrder.size())
      begin
        flowErrors++;
        $display("%0t: header of table row %0d never left the output", $time, k);
      end
      else if (hdrOrder[idx] != stimTable[k].port)
      begin
        valueErrors++;
        $display("[FAIL] %0t outFlit header port: expected %0d, got %0d",
                 $time, stimTable[k].port, hdrOrder[idx]);
      end
    end
  endtask

  task automatic buildTable();
    stimTable[0]  = '{PORT_L, 12'd3, 1'b0, 1'b0, 3'd0}; // one packet per port
    stimTable[1]  = '{PORT_N, 12'd1, 1'b0, 1'b0, 3'd0};
    stimTable[2]  = '{PORT_E, 12'd5, 1'b0, 1'b0, 3'd0};
    stimTable[3]  = '{PORT_W, 12'd2, 1'b0, 1'b0, 3'd0};
    stimTable[4]  = '{PORT_S, 12'd8, 1'b0, 1'b0, 3'd0};
    stimTable[5]  = '{PORT_L, 12'd4, 1'b1, 1'b0, 3'd0}; // preload, local then rotation
    stimTable[6]  = '{PORT_N, 12'd3, 1'b1, 1'b0, 3'd1};
    stimTable[7]  = '{PORT_E, 12'd6, 1'b1, 1'b0, 3'd2};
    stimTable[8]  = '{PORT_W, 12'd2, 1'b1, 1'b0, 3'd3};
    stimTable[9]  = '{PORT_S, 12'd5, 1'b1, 1'b0, 3'd4};
    stimTable[10] = '{PORT_L, 12'd1, 1'b1, 1'b0, 3'd0}; // occupies the output register
    stimTable[11] = '{PORT_N, 12'd8, 1'b1, 1'b0, 3'd1};
    stimTable[12] = '{PORT_N, 12'd1, 1'b1, 1'b1, 3'd2}; // ninth flit on N
    for (int r = 13; r < NUM_ROWS; r++)
      stimTable[r] = '{portIdxT'($urandom % `NUM_PORTS), pktLenT'(1 + $urandom % 8),
                       1'b0, 1'b0, 3'd0};
  endtask

  initial
  begin : mainFlow
    rowT  row;
    rowT  nextRow;
    int   groupFirst;
    int   hdrStart;
    int   n;
    inReq       = '0;
    inFlit      = '0;
    holdAck     = 1'b0;
    remaining   = 0;
    curPort     = PORT_L;
    valueErrors = 0;
    flowErrors  = 0;
    groupFirst  = 0;
    hdrStart    = 0;
    void'($urandom(32'hb11e));
    buildTable();
    n = 0;
    while (rst !== 1'b0 && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0)
      flagTimeout("reset was never released");
    for (int r = 0; r < NUM_ROWS && !timedOut; r++)
    begin
      row     = stimTable[r];
      nextRow = '0;
      if (r + 1 < NUM_ROWS)
        nextRow = stimTable[r + 1];
      if (row.preload && row.expSlot == 3'd0)
      begin
        drainOutput($sformatf("rows before %0d", r));
        groupFirst = r;
        hdrStart   = hdrOrder.size();
        holdAck    = 1'b1;
      end
      sendPacket(row);
      if (row.preload && (!nextRow.preload || nextRow.expSlot == 3'd0))
      begin
        holdAck = 1'b0;
        drainOutput($sformatf("held group ending at row %0d", r));
        if (!timedOut)
          checkGroupOrder(groupFirst, r, hdrStart);
      end
    end
    drainOutput("the last table row");
    printCounts();
    if (!timedOut && valueErrors == 0 && flowErrors == 0 && DUT.uSva.assertFails == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // downstream node with a random ack delay
  initial
  begin : ackResponder
    int delay;
    int n;
    outAck = 1'b0;
    n = 0;
    while (rst !== 1'b0 && n < 100)
    begin
      @(negedge clk);
      n++;
    end
    while (!timedOut)
    begin
      n = 0;
      while ((outReq !== 1'b1 || holdAck) && n < IDLE_TIMEOUT && !timedOut)
      begin
        @(negedge clk);
        n++;
      end
      if (outReq !== 1'b1 || holdAck)
        flagTimeout("no flit was offered on the output for too long");
      else
      begin
        delay = 1 + int'($urandom % 6);
        repeat (delay) @(negedge clk);
        checkFlit(outFlit);
        outAck = 1'b1;
        n = 0;
        while (outReq && n < LINK_TIMEOUT && !timedOut)
        begin
          @(negedge clk);
          n++;
        end
        if (outReq)
          flagTimeout("outReq did not fall after outAck");
        outAck = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/linkReceiver.sv
rtl/flitFifo.sv
rtl/packetArbiter.sv
rtl/outputLink.sv
rtl/routerOutputStage.sv
tests/tbClock.sv
tests/routerOutputStage_sva.sv
tests/routerOutputStage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= routerOutputStage_tb
FILELIST  ?= sim.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
